//--- compile.f
verilog/nmcu_cfg_pkg.sv
verilog/nmcu_layer_pkg.sv
verilog/nmcu_ifs.sv
verilog/nmcu_sequencer.sv
verilog/nmcu_scan_counter.sv
verilog/nmcu_desc_store.sv
verilog/nmcu_act_buffer.sv
verilog/nmcu_layer_alu.sv
verilog/nmcu_top.sv
verif/tb_nmcu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
        --top-module tb_nmcu -f compile.f -o sim_nmcu; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_nmcu)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

//--- verif/tb_nmcu.sv
module tb_nmcu
    import nmcu_cfg_pkg::*, nmcu_layer_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 100;
    localparam int desc_base  = 'h0100;
    localparam int img_base   = 'h1000;
    localparam int out_base   = 'h4000;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        start = 1'b0;
    addr_t       nmcu_desc = '0;
    addr_t       input_addr = '0;
    addr_t       output_addr = '0;
    dim_t        full_input_width = '0;
    logic        mem_sel;
    logic        mem_w;
    addr_t       mem_addr;
    data_t       mem_wdata;
    data_t       mem_rdata = '0;
    logic        mem_ready = 1'b0;
    nmcu_state_t state_out;

    // memory contents, and the words written back by the DUT
    int   mem [int];
    int   out_mem [int];
    logic busy = 1'b0;
    int   wait_left = 0;
    int   desc_reads = 0;
    int   bad_reads = 0;
    int   stray_writes = 0;
    int   write_count = 0;

    // reference model
    int          model_tile [max_dim][max_dim];
    int          tile_w;
    int          tile_h;
    int          exp_out_len = 0;
    logic [31:0] desc_words [$];

    string cur_test = "startup";
    int    err_count = 0;
    int    errs_at_start = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    time   deadline = 100000;

    always #(clk_period / 2) clk = ~clk;

    nmcu_top u_nmcu_top (
        .clk              (clk),
        .rst              (rst),
        .start            (start),
        .nmcu_desc        (nmcu_desc),
        .input_addr       (input_addr),
        .output_addr      (output_addr),
        .full_input_width (full_input_width),
        .mem_sel          (mem_sel),
        .mem_w            (mem_w),
        .mem_addr         (mem_addr),
        .mem_wdata        (mem_wdata),
        .mem_rdata        (mem_rdata),
        .mem_ready        (mem_ready),
        .state_out        (state_out)
    );

    // memory model answering each strobe after 0 to 3 cycles with a one-cycle ready
    always @(negedge clk) begin
        if (rst) begin
            mem_ready = 1'b0;
            busy = 1'b0;
            desc_reads = 0;
            bad_reads = 0;
            stray_writes = 0;
            write_count = 0;
            out_mem.delete();
        end else if (mem_ready) begin
            mem_ready = 1'b0;
            busy = 1'b0;
        end else if (mem_sel) begin
            if (!busy) begin
                busy = 1'b1;
                wait_left = $urandom_range(3, 0);
            end
            if (wait_left == 0) begin
                if (mem_w) begin
                    write_count++;
                    if (int'(mem_addr) >= int'(output_addr)
                            && int'(mem_addr) < int'(output_addr) + exp_out_len) begin
                        out_mem[int'(mem_addr)] = mem_wdata;
                    end else begin
                        stray_writes++;
                    end
                end else begin
                    if (int'(mem_addr) >= desc_base && int'(mem_addr) < desc_base + 16) begin
                        desc_reads++;
                    end
                    if (mem.exists(int'(mem_addr))) begin
                        mem_rdata = mem[int'(mem_addr)];
                    end else begin
                        bad_reads++;
                        mem_rdata = '0;
                    end
                end
                mem_ready = 1'b1;
            end else begin
                wait_left--;
            end
        end
    end

    initial begin : watchdog
        while ($time <= deadline) begin
            @(posedge clk);
        end
        $display("timeout: %s did not reach the finished state in time", cur_test);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("ERROR %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok) else begin
            $display("%s: %s", cur_test, what);
            err_count++;
        end
    endtask

    task automatic arm_watchdog(input int cycles);
        deadline = $time + cycles * clk_period;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        start = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        errs_at_start = err_count;
        desc_words.delete();
    endtask

    task automatic end_test();
        tests_run++;
        if (err_count == errs_at_start) begin
            $display("test %-16s ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %-16s failed, %0d bad checks", cur_test, err_count - errs_at_start);
        end
    endtask

    // type in bits 1:0, width in 5:2, height in 9:6
    function automatic logic [31:0] make_desc(input layer_type_t lt, input int w, input int h);
        logic [31:0] d;
        d = '0;
        d[1:0] = lt;
        d[5:2] = w[3:0];
        d[9:6] = h[3:0];
        return d;
    endfunction

    task automatic apply_relu();
        int r;
        int c;
        for (r = 0; r < tile_h; r++) begin
            for (c = 0; c < tile_w; c++) begin
                if (model_tile[r][c] < 0) begin
                    model_tile[r][c] = 0;
                end
            end
        end
    endtask

    task automatic apply_maxp();
        int r;
        int c;
        int m;
        // works in place as output (r, c) never lands on a window still to be read
        for (r = 0; r < tile_h / 2; r++) begin
            for (c = 0; c < tile_w / 2; c++) begin
                m = model_tile[2 * r][2 * c];
                if (model_tile[2 * r][2 * c + 1] > m) begin
                    m = model_tile[2 * r][2 * c + 1];
                end
                if (model_tile[2 * r + 1][2 * c] > m) begin
                    m = model_tile[2 * r + 1][2 * c];
                end
                if (model_tile[2 * r + 1][2 * c + 1] > m) begin
                    m = model_tile[2 * r + 1][2 * c + 1];
                end
                model_tile[r][c] = m;
            end
        end
        tile_w = tile_w / 2;
        tile_h = tile_h / 2;
    endtask

    // random relu/max-pool layers, max-pool only while both edges are at least 2
    task automatic push_layers(input int n, input int w0, input int h0);
        int k;
        int w;
        int h;
        layer_type_t lt;
        w = w0;
        h = h0;
        for (k = 0; k < n; k++) begin
            lt = (w >= 2 && h >= 2 && $urandom_range(1, 0) == 1) ? layer_maxp : layer_relu;
            if (k == 0) begin
                desc_words.push_back(make_desc(lt, w, h));
            end else begin
                // later descriptors carry sizes that must be ignored
                desc_words.push_back(make_desc(lt, $urandom_range(15, 1), $urandom_range(15, 1)));
            end
            if (lt == layer_maxp) begin
                w = w / 2;
                h = h / 2;
            end
        end
    endtask

    task automatic run_job();
        int img_w;
        int row_off;
        int col_off;
        int in_base;
        int out_start;
        int in_elems;
        int fetched;
        int layer_elems;
        int k;
        int r;
        int c;
        int a;
        layer_type_t lt;

        arm_watchdog(20);
        apply_reset();
        mem.delete();
        tile_w = int'(desc_words[0][5:2]);
        tile_h = int'(desc_words[0][9:6]);
        img_w = $urandom_range(15, tile_w);
        row_off = $urandom_range(2, 0);
        col_off = $urandom_range(img_w - tile_w, 0);
        for (k = 0; k < img_w * (tile_h + row_off); k++) begin
            mem[img_base + k] = $urandom;
        end
        in_base = img_base + row_off * img_w + col_off;
        out_start = out_base + $urandom_range(255, 0);
        for (r = 0; r < tile_h; r++) begin
            for (c = 0; c < tile_w; c++) begin
                model_tile[r][c] = mem[in_base + r * img_w + c];
            end
        end
        for (k = 0; k < desc_words.size(); k++) begin
            mem[desc_base + k] = desc_words[k];
        end

        // fetch stops at the first nop or after eight words
        fetched = 0;
        while (fetched < max_descs) begin
            fetched++;
            if (desc_words[fetched - 1][1:0] == 2'd0) begin
                break;
            end
        end
        in_elems = tile_w * tile_h;
        layer_elems = 0;
        for (k = 0; k < fetched; k++) begin
            lt = layer_type_t'(desc_words[k][1:0]);
            if (lt == layer_nop || lt == layer_conv) begin
                break;
            end
            if (lt == layer_relu) begin
                apply_relu();
            end else begin
                apply_maxp();
            end
            layer_elems += tile_w * tile_h;
        end
        exp_out_len = tile_w * tile_h;

        nmcu_desc = addr_t'(desc_base);
        input_addr = addr_t'(in_base);
        output_addr = addr_t'(out_start);
        full_input_width = dim_t'(img_w);
        arm_watchdog(8 * (fetched + in_elems + layer_elems + exp_out_len) + 20);
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (state_out != st_finished) @(negedge clk);
        repeat (3) @(negedge clk);

        check_true(state_out == st_finished && !mem_sel, "did not stay finished with the bus idle");
        check_value("descriptor reads", fetched, desc_reads);
        check_value("words written", exp_out_len, write_count);
        check_value("writes outside output range", 0, stray_writes);
        check_value("reads from unset memory", 0, bad_reads);
        for (r = 0; r < tile_h; r++) begin
            for (c = 0; c < tile_w; c++) begin
                a = out_start + r * tile_w + c;
                if (out_mem.exists(a)) begin
                    check_value($sformatf("out[%0d][%0d]", r, c), model_tile[r][c], out_mem[a]);
                end else begin
                    check_true(1'b0, $sformatf("output word %0d,%0d never written", r, c));
                end
            end
        end
    endtask

    initial begin
        int n;
        int tw;
        int th;

        void'($urandom(59));

        begin_test("reset_idle");
        arm_watchdog(60);
        apply_reset();
        check_true(!mem_sel && !mem_w, "memory strobes active after reset");
        check_value("state after reset", int'(st_idle), int'(state_out));
        repeat (20) @(negedge clk);
        check_true(!mem_sel && !mem_w, "memory accessed without start");
        check_value("state without start", int'(st_idle), int'(state_out));
        end_test();

        begin_test("passthrough");
        desc_words.push_back(make_desc(layer_nop, $urandom_range(15, 1), $urandom_range(15, 1)));
        run_job();
        end_test();

        begin_test("single_relu");
        desc_words.push_back(make_desc(layer_relu, $urandom_range(15, 1), $urandom_range(15, 1)));
        desc_words.push_back(make_desc(layer_nop, 0, 0));
        run_job();
        end_test();

        begin_test("single_maxpool");
        desc_words.push_back(make_desc(layer_maxp, $urandom_range(15, 2), $urandom_range(15, 2)));
        desc_words.push_back(make_desc(layer_nop, 0, 0));
        run_job();
        end_test();

        for (n = 0; n < 3; n++) begin
            begin_test($sformatf("random_chain_%0d", n));
            tw = $urandom_range(15, 1);
            th = $urandom_range(15, 1);
            push_layers($urandom_range(7, 1), tw, th);
            // conv ends the chain but not the descriptor fetch
            if ($urandom_range(1, 0) == 1) begin
                desc_words.push_back(make_desc(layer_conv, tw, th));
            end
            desc_words.push_back(make_desc(layer_nop, tw, th));
            run_job();
            end_test();
        end

        begin_test("eight_layers");
        push_layers(8, $urandom_range(15, 1), $urandom_range(15, 1));
        // a ninth descriptor that must never be fetched
        desc_words.push_back(make_desc(layer_relu, 3, 3));
        run_job();
        end_test();

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/nmcu_top.sv
module nmcu_top
    import nmcu_cfg_pkg::*, nmcu_layer_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  addr_t       nmcu_desc,
    input  addr_t       input_addr,
    input  addr_t       output_addr,
    input  dim_t        full_input_width,
    output logic        mem_sel,
    output logic        mem_w,
    output addr_t       mem_addr,
    output data_t       mem_wdata,
    input  data_t       mem_rdata,
    input  logic        mem_ready,
    output nmcu_state_t state_out
);

    desc_t       cur_desc;
    desc_cnt_t   desc_count;
    logic        desc_we;
    desc_idx_t   desc_idx;
    mem_word_u   rdata;
    logic        act_we;
    logic        act_sel_flip;
    logic        act_fill;
    dim_t        wr_row;
    dim_t        wr_col;
    data_t       wr_data;
    logic        alu_load;
    layer_type_t alu_op;
    data_t       alu_result;
    data_t       pix;
    data_t       win00;
    data_t       win01;
    data_t       win10;
    data_t       win11;

    scan_if scan ();

    nmcu_sequencer u_sequencer (
        .clk              (clk),
        .rst              (rst),
        .start            (start),
        .nmcu_desc        (nmcu_desc),
        .input_addr       (input_addr),
        .output_addr      (output_addr),
        .full_input_width (full_input_width),
        .mem_sel          (mem_sel),
        .mem_w            (mem_w),
        .mem_addr         (mem_addr),
        .mem_wdata        (mem_wdata),
        .mem_rdata        (mem_rdata),
        .mem_ready        (mem_ready),
        .state_out        (state_out),
        .scan             (scan),
        .cur_desc         (cur_desc),
        .desc_count       (desc_count),
        .desc_we          (desc_we),
        .desc_idx         (desc_idx),
        .rdata            (rdata),
        .act_we           (act_we),
        .act_sel_flip     (act_sel_flip),
        .act_fill         (act_fill),
        .wr_row           (wr_row),
        .wr_col           (wr_col),
        .wr_data          (wr_data),
        .alu_load         (alu_load),
        .alu_op           (alu_op),
        .alu_result       (alu_result),
        .act_rdata        (pix)
    );

    nmcu_scan_counter u_scan_counter (
        .clk  (clk),
        .rst  (rst),
        .scan (scan)
    );

    // same index for fetch writes and chain reads
    nmcu_desc_store u_desc_store (
        .clk        (clk),
        .rst        (rst),
        .we         (desc_we),
        .idx        (desc_idx),
        .wdata      (rdata),
        .cur_idx    (desc_idx),
        .cur_desc   (cur_desc),
        .desc_count (desc_count)
    );

    nmcu_act_buffer u_act_buffer (
        .clk     (clk),
        .rst     (rst),
        .we      (act_we),
        .flip    (act_sel_flip),
        .fill    (act_fill),
        .wr_row  (wr_row),
        .wr_col  (wr_col),
        .wr_data (wr_data),
        .rd_row  (scan.row),
        .rd_col  (scan.col),
        .pix     (pix),
        .win00   (win00),
        .win01   (win01),
        .win10   (win10),
        .win11   (win11)
    );

    nmcu_layer_alu u_layer_alu (
        .clk    (clk),
        .rst    (rst),
        .load   (alu_load),
        .op     (alu_op),
        .pix    (pix),
        .win00  (win00),
        .win01  (win01),
        .win10  (win10),
        .win11  (win11),
        .result (alu_result)
    );

endmodule

//--- verilog/nmcu_layer_alu.sv
module nmcu_layer_alu
    import nmcu_cfg_pkg::*, nmcu_layer_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        load,
    input  layer_type_t op,
    input  data_t       pix,
    input  data_t       win00,
    input  data_t       win01,
    input  data_t       win10,
    input  data_t       win11,
    output data_t       result
);

    data_t top_max;
    data_t bot_max;
    data_t win_max;
    data_t relu_val;

    // max of each window row, then of the two rows
    assign top_max  = (win01 > win00) ? win01 : win00;
    assign bot_max  = (win11 > win10) ? win11 : win10;
    assign win_max  = (bot_max > top_max) ? bot_max : top_max;
    assign relu_val = pix[data_w-1] ? '0 : pix;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else if (load) begin
            result <= (op == layer_maxp) ? win_max : relu_val;
        end
    end

endmodule

//--- verilog/nmcu_act_buffer.sv
module nmcu_act_buffer
    import nmcu_cfg_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  we,
    input  logic  flip,
    input  logic  fill,
    input  dim_t  wr_row,
    input  dim_t  wr_col,
    input  data_t wr_data,
    input  dim_t  rd_row,
    input  dim_t  rd_col,
    output data_t pix,
    output data_t win00,
    output data_t win01,
    output data_t win10,
    output data_t win11
);

    data_t banks [2][max_dim][max_dim];
    logic  in_bank;
    logic  wr_bank;
    dim_t  win_r0;
    dim_t  win_r1;
    dim_t  win_c0;
    dim_t  win_c1;

    // tile fetch fills the input bank, layers write the other one
    assign wr_bank = fill ? in_bank : ~in_bank;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_bank <= 1'b0;
        end else if (flip) begin
            in_bank <= ~in_bank;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            banks[wr_bank][wr_row][wr_col] <= wr_data;
        end
    end

    // 2x2 window at twice the output position
    assign win_r0 = {rd_row[dim_w-2:0], 1'b0};
    assign win_r1 = {rd_row[dim_w-2:0], 1'b1};
    assign win_c0 = {rd_col[dim_w-2:0], 1'b0};
    assign win_c1 = {rd_col[dim_w-2:0], 1'b1};

    assign pix   = banks[in_bank][rd_row][rd_col];
    assign win00 = banks[in_bank][win_r0][win_c0];
    assign win01 = banks[in_bank][win_r0][win_c1];
    assign win10 = banks[in_bank][win_r1][win_c0];
    assign win11 = banks[in_bank][win_r1][win_c1];

endmodule

//--- verilog/nmcu_desc_store.sv
module nmcu_desc_store
    import nmcu_cfg_pkg::*, nmcu_layer_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      we,
    input  desc_idx_t idx,
    input  mem_word_u wdata,
    input  desc_idx_t cur_idx,
    output desc_t     cur_desc,
    output desc_cnt_t desc_count
);

    desc_t descs [max_descs];

    always_ff @(posedge clk) begin
        if (we) begin
            descs[idx] <= wdata.desc;
        end
    end

    // descriptors arrive in order, so the count follows the last index written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            desc_count <= '0;
        end else if (we) begin
            desc_count <= desc_cnt_t'(idx) + desc_cnt_t'(1);
        end
    end

    assign cur_desc = descs[cur_idx];

endmodule

//--- verilog/nmcu_scan_counter.sv
module nmcu_scan_counter
    import nmcu_cfg_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    scan_if.counter scan
);

    dim_t row;
    dim_t col;
    dim_t last_col;
    dim_t last_row;

    assign last_col = scan.width - 1'b1;
    assign last_row = scan.height - 1'b1;

    assign scan.row       = row;
    assign scan.col       = col;
    assign scan.row_last  = (col == last_col);
    assign scan.done_last = scan.row_last && (row == last_row);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row <= '0;
            col <= '0;
        end else if (scan.clear) begin
            // clear wins over a step in the same cycle
            row <= '0;
            col <= '0;
        end else if (scan.step) begin
            if (scan.row_last) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

//--- verilog/nmcu_sequencer.sv
module nmcu_sequencer
    import nmcu_cfg_pkg::*, nmcu_layer_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  addr_t       nmcu_desc,
    input  addr_t       input_addr,
    input  addr_t       output_addr,
    input  dim_t        full_input_width,
    output logic        mem_sel,
    output logic        mem_w,
    output addr_t       mem_addr,
    output data_t       mem_wdata,
    input  data_t       mem_rdata,
    input  logic        mem_ready,
    output nmcu_state_t state_out,
    scan_if.ctrl        scan,
    input  desc_t       cur_desc,
    input  desc_cnt_t   desc_count,
    output logic        desc_we,
    output desc_idx_t   desc_idx,
    output mem_word_u   rdata,
    output logic        act_we,
    output logic        act_sel_flip,
    output logic        act_fill,
    output dim_t        wr_row,
    output dim_t        wr_col,
    output data_t       wr_data,
    output logic        alu_load,
    output layer_type_t alu_op,
    input  data_t       alu_result,
    input  data_t       act_rdata
);

    nmcu_state_t state;
    nmcu_state_t dispatch_state;
    desc_idx_t   idx;
    dim_t        size_w;
    dim_t        size_h;
    logic        phase;
    logic        in_layer;
    logic        mem_done;
    logic        layer_step;
    logic        layer_last;
    logic        chain_end;
    logic        fetch_stop;
    mem_word_u   rd_word;

    function automatic nmcu_state_t layer_state(input layer_type_t ltype);
        case (ltype)
            layer_maxp: return st_maxp;
            layer_relu: return st_relu;
            // nop and conv both close the chain
            default:    return st_nop;
        endcase
    endfunction

    assign rd_word    = mem_rdata;
    assign mem_done   = mem_sel && mem_ready;
    assign in_layer   = (state == st_maxp) || (state == st_relu);
    assign layer_step = in_layer && phase;
    assign layer_last = layer_step && scan.done_last;
    assign chain_end  = (desc_cnt_t'(idx) + desc_cnt_t'(1)) == desc_count;

    // descriptor fetch ends at a nop or on the last slot
    assign fetch_stop = (idx == desc_idx_t'(max_descs - 1))
                        || (rd_word.desc.ltype == layer_nop);

    // look one descriptor ahead on the last element so the next layer is known
    assign desc_idx       = layer_last ? idx + 1'b1 : idx;
    assign dispatch_state = layer_state(cur_desc.ltype);

    // max-pool scans its halved output grid
    assign scan.width  = (state == st_maxp) ? (size_w >> 1) : size_w;
    assign scan.height = (state == st_maxp) ? (size_h >> 1) : size_h;
    assign scan.step   = (((state == st_read_inputs) || (state == st_nop)) && mem_done)
                         || layer_step;
    assign scan.clear  = (state == st_idle) || (scan.step && scan.done_last);

    assign desc_we = (state == st_read_descs) && mem_done;
    assign rdata   = rd_word;

    assign act_fill     = (state == st_read_inputs);
    assign act_we       = (act_fill && mem_done) || layer_step;
    assign act_sel_flip = layer_last;
    assign wr_row       = scan.row;
    assign wr_col       = scan.col;
    assign wr_data      = act_fill ? rd_word.act : alu_result;

    assign alu_load = in_layer && !phase;
    assign alu_op   = (state == st_maxp) ? layer_maxp : layer_relu;

    assign state_out = state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            idx      <= '0;
            size_w   <= '0;
            size_h   <= '0;
            phase    <= 1'b0;
            mem_sel  <= 1'b0;
            mem_w    <= 1'b0;
            mem_addr <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state    <= st_read_descs;
                        mem_sel  <= 1'b1;
                        mem_addr <= nmcu_desc;
                        idx      <= '0;
                    end
                end
                st_read_descs: begin
                    if (!mem_sel) begin
                        mem_sel <= 1'b1;
                    end else if (mem_ready) begin
                        mem_sel <= 1'b0;
                        // only descriptor 0 sets the tile size
                        if (idx == '0) begin
                            size_w <= rd_word.desc.width;
                            size_h <= rd_word.desc.height;
                        end
                        if (fetch_stop) begin
                            state    <= st_read_inputs;
                            idx      <= '0;
                            mem_addr <= input_addr;
                        end else begin
                            idx      <= idx + 1'b1;
                            mem_addr <= mem_addr + 1'b1;
                        end
                    end
                end
                st_read_inputs: begin
                    if (!mem_sel) begin
                        mem_sel <= 1'b1;
                    end else if (mem_ready) begin
                        mem_sel <= 1'b0;
                        if (scan.done_last) begin
                            state    <= dispatch_state;
                            mem_addr <= output_addr;
                        end else if (scan.row_last) begin
                            // jump to the start of the next tile row in the image
                            mem_addr <= mem_addr + addr_t'(full_input_width)
                                        - addr_t'(size_w) + 1'b1;
                        end else begin
                            mem_addr <= mem_addr + 1'b1;
                        end
                    end
                end
                st_maxp, st_relu: begin
                    phase <= ~phase;
                    if (layer_last) begin
                        size_w   <= scan.width;
                        size_h   <= scan.height;
                        idx      <= idx + 1'b1;
                        state    <= chain_end ? st_nop : dispatch_state;
                        mem_addr <= output_addr;
                    end
                end
                st_nop: begin
                    if (!mem_sel) begin
                        mem_sel <= 1'b1;
                        mem_w   <= 1'b1;
                    end else if (mem_ready) begin
                        mem_sel  <= 1'b0;
                        mem_w    <= 1'b0;
                        mem_addr <= mem_addr + 1'b1;
                        if (scan.done_last) begin
                            state <= st_finished;
                        end
                    end
                end
                default: begin
                    // finished, parked until reset
                end
            endcase
        end
    end

    // write data is latched as the strobe goes up and held through the access
    always_ff @(posedge clk) begin
        if (state == st_nop && !mem_sel) begin
            mem_wdata <= act_rdata;
        end
    end

endmodule

//--- verilog/nmcu_ifs.sv
// row/column scan between the sequencer and the scan counter
interface scan_if
    import nmcu_cfg_pkg::*;
();

    // from the sequencer
    logic clear;
    logic step;
    dim_t width;
    dim_t height;

    // from the counter
    dim_t row;
    dim_t col;
    logic row_last;
    logic done_last;

    modport ctrl (
        output clear,
        output step,
        output width,
        output height,
        input  row,
        input  col,
        input  row_last,
        input  done_last
    );

    modport counter (
        input  clear,
        input  step,
        input  width,
        input  height,
        output row,
        output col,
        output row_last,
        output done_last
    );

endinterface

//--- verilog/nmcu_layer_pkg.sv
package nmcu_layer_pkg;

    import nmcu_cfg_pkg::*;

    localparam int desc_w = 32;
    localparam int layer_type_w = 2;
    localparam int desc_rsvd_w = desc_w - layer_type_w - 2 * dim_w;

    // descriptor layer type field
    typedef enum logic [layer_type_w-1:0] {
        layer_nop  = 2'd0,
        layer_conv = 2'd1,
        layer_maxp = 2'd2,
        layer_relu = 2'd3
    } layer_type_t;

    // descriptor word as laid out in memory, lsb first: type, width, height
    typedef struct packed {
        logic [desc_rsvd_w-1:0] rsvd;
        dim_t                   height;
        dim_t                   width;
        layer_type_t            ltype;
    } desc_t;

    // one read word, a descriptor during descriptor fetch
    // and an activation during tile fetch
    typedef union packed {
        desc_t desc;
        data_t act;
    } mem_word_u;

    // visible on state_out
    typedef enum logic [3:0] {
        st_idle        = 4'd0,
        st_read_descs  = 4'd1,
        st_read_inputs = 4'd2,
        st_nop         = 4'd3,
        st_maxp        = 4'd4,
        st_relu        = 4'd5,
        st_finished    = 4'd6
    } nmcu_state_t;

endpackage

//--- verilog/nmcu_cfg_pkg.sv
package nmcu_cfg_pkg;

    // memory side
    localparam int addr_w = 16;
    localparam int data_w = 32;

    // descriptor file depth
    localparam int max_descs = 8;
    localparam int desc_idx_w = $clog2(max_descs);
    // one extra bit so a full file of eight can be counted
    localparam int desc_cnt_w = $clog2(max_descs + 1);

    // largest tile edge held in the local banks
    localparam int max_dim = 15;
    localparam int dim_w = 4;

    typedef logic [addr_w-1:0] addr_t;

    // activations are signed words
    typedef logic signed [data_w-1:0] data_t;

    // tile row, column and size
    typedef logic [dim_w-1:0] dim_t;

    typedef logic [desc_idx_w-1:0] desc_idx_t;
    typedef logic [desc_cnt_w-1:0] desc_cnt_t;

endpackage
